//--- src/proc_defs.svh
//////////////////////////////////////////////////
// Width and field macros for the execute slice
// Include wherever a width or field position is needed
//////////////////////////////////////////////////
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

`define PROC_DATA_WIDTH     16  // Register and result width
`define PROC_NUM_REGS       8   // Register file depth
`define PROC_INSTR_WIDTH    16  // One instruction word
`define PROC_REG_IDX_WIDTH  3   // log2 of register count
`define PROC_OPC_WIDTH      4
`define PROC_SHAMT_WIDTH    4   // Shift amount from rs2 low bits
`define PROC_IMM_WIDTH      9

// Instruction field positions
`define PROC_OPC_MSB  15
`define PROC_OPC_LSB  12
`define PROC_RD_MSB   11
`define PROC_RD_LSB   9
`define PROC_RS1_MSB  8
`define PROC_RS1_LSB  6
`define PROC_RS2_MSB  5
`define PROC_RS2_LSB  3
`define PROC_IMM_MSB  8   // imm9 overlaps rs1 and rs2
`define PROC_IMM_LSB  0

`endif

//--- src/proc_isa_pkg.sv
//////////////////////////////////////////////////
// Instruction-set types shared by decoder and units
// Opcode encodings and the register index type
//////////////////////////////////////////////////
`default_nettype none

`include "proc_defs.svh"

package proc_isa_pkg;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////
  // Four-bit field, codes 10..15 left unassigned
  typedef enum logic [`PROC_OPC_WIDTH-1:0] {
    NOP = 4'd0,   // No result written
    AND = 4'd1,
    OR  = 4'd2,
    XOR = 4'd3,
    NOT = 4'd4,   // rs1 only
    ADD = 4'd5,
    SUB = 4'd6,
    SLL = 4'd7,   // Shift by rs2[3:0]
    SRL = 4'd8,
    LDI = 4'd9    // Zero-extended imm9
  } opcode_e;

  //////////////////////////////////////////////////
  // Register index
  //////////////////////////////////////////////////
  typedef logic [`PROC_REG_IDX_WIDTH-1:0] reg_idx_t;

endpackage

`default_nettype wire

//--- src/proc_exec_pkg.sv
//////////////////////////////////////////////////
// Execution-side types
// Result source select and decoded control word
//////////////////////////////////////////////////
`default_nettype none

`include "proc_defs.svh"

package proc_exec_pkg;
  import proc_isa_pkg::*;

  // Which unit owns the writeback value
  typedef enum logic [1:0] {
    UNIT_NONE  = 2'd0,  // NOP and illegal codes, result zero
    UNIT_GATE  = 2'd1,
    UNIT_ARITH = 2'd2,
    UNIT_IMM   = 2'd3   // LDI
  } unit_sel_e;

  // Decoder to writeback
  typedef struct packed {
    unit_sel_e                   unit_sel;
    reg_idx_t                    rd;       // Destination
    logic                        we;       // Write the register file
    logic                        illegal;  // Opcode 10..15
    logic [`PROC_DATA_WIDTH-1:0] imm;      // Already zero-extended
  } dec_ctrl_t;

endpackage

`default_nettype wire

//--- src/alu_op_if.sv
//////////////////////////////////////////////////
// Operand and result bundle for one function unit
// Unit side gets operands, sink side reads the result
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

interface alu_op_if
  import proc_isa_pkg::*;
();

  logic [`PROC_DATA_WIDTH-1:0] operand_a;  // rs1 read data
  logic [`PROC_DATA_WIDTH-1:0] operand_b;  // rs2 read data
  opcode_e                     opcode;     // Straight from the decoder
  logic [`PROC_DATA_WIDTH-1:0] result;

  // Function unit view
  modport unit (
    input  operand_a,
    input  operand_b,
    input  opcode,
    output result
  );

  // Writeback view, result only
  modport sink (
    input  result
  );

endinterface

`default_nettype wire

//--- src/instr_decoder.sv
//////////////////////////////////////////////////
// Instruction decoder, purely combinational
// Splits the word into fields and builds the control for writeback
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module instr_decoder
  import proc_isa_pkg::*;
  import proc_exec_pkg::*;
(
  input  logic [`PROC_INSTR_WIDTH-1:0] instr_i,
  output opcode_e                      opcode_o,  // To both units
  output reg_idx_t                     rs1_o,     // Register file read A
  output reg_idx_t                     rs2_o,     // Register file read B
  output dec_ctrl_t                    ctrl_o
);

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////
  logic [`PROC_OPC_WIDTH-1:0] opc_field;
  logic [`PROC_IMM_WIDTH-1:0] imm_field;

  assign opc_field = instr_i[`PROC_OPC_MSB:`PROC_OPC_LSB];
  assign imm_field = instr_i[`PROC_IMM_MSB:`PROC_IMM_LSB];
  assign opcode_o  = opcode_e'(opc_field);  // Illegal codes pass through, units give zero
  assign rs1_o     = instr_i[`PROC_RS1_MSB:`PROC_RS1_LSB];
  assign rs2_o     = instr_i[`PROC_RS2_MSB:`PROC_RS2_LSB];

  //////////////////////////////////////////////////
  // Opcode classification
  //////////////////////////////////////////////////
  always_comb begin
    ctrl_o          = '0;
    ctrl_o.rd       = instr_i[`PROC_RD_MSB:`PROC_RD_LSB];
    ctrl_o.unit_sel = UNIT_NONE;
    case (opcode_o)
      NOP: begin
        ctrl_o.we = 1'b0;  // Legal, but nothing to write
      end
      AND, OR, XOR, NOT: begin
        ctrl_o.unit_sel = UNIT_GATE;
        ctrl_o.we       = 1'b1;
      end
      ADD, SUB, SLL, SRL: begin
        ctrl_o.unit_sel = UNIT_ARITH;
        ctrl_o.we       = 1'b1;
      end
      LDI: begin
        ctrl_o.unit_sel = UNIT_IMM;
        ctrl_o.we       = 1'b1;
        // imm9 zero-extended to data width
        ctrl_o.imm = {{(`PROC_DATA_WIDTH-`PROC_IMM_WIDTH){1'b0}}, imm_field};
      end
      default: begin
        ctrl_o.illegal = 1'b1;  // Codes 10..15, no write
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/reg_file.sv
//////////////////////////////////////////////////
// Eight-entry register file
// Two combinational read ports, one write port at the clock edge
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module reg_file
  import proc_isa_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Read side
  input  reg_idx_t                    rs1_i,
  input  reg_idx_t                    rs2_i,
  output logic [`PROC_DATA_WIDTH-1:0] rs1_data_o,
  output logic [`PROC_DATA_WIDTH-1:0] rs2_data_o,
  // Write side, driven by writeback
  input  logic                        we_i,
  input  reg_idx_t                    wr_idx_i,
  input  logic [`PROC_DATA_WIDTH-1:0] wr_data_i
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////
  // Register 0 is a normal register, not hardwired to zero
  logic [`PROC_DATA_WIDTH-1:0] regs_q [`PROC_NUM_REGS];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `PROC_NUM_REGS; i++) begin
        regs_q[i] <= '0;  // All registers read zero after reset
      end
    end else if (we_i) begin
      regs_q[wr_idx_i] <= wr_data_i;  // Lands with the instruction's own edge
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////
  // No bypass; a write is already visible one cycle later
  assign rs1_data_o = regs_q[rs1_i];
  assign rs2_data_o = regs_q[rs2_i];

endmodule

`default_nettype wire

//--- src/alu_gate.sv
//////////////////////////////////////////////////
// Logic gate unit
// Bitwise AND, OR, XOR and NOT on the register operands
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module alu_gate
  import proc_isa_pkg::*;
(
  alu_op_if.unit op
);

  //////////////////////////////////////////////////
  // Bitwise operations
  //////////////////////////////////////////////////
  always_comb begin
    case (op.opcode)
      AND:     op.result = op.operand_a & op.operand_b;
      OR:      op.result = op.operand_a | op.operand_b;
      XOR:     op.result = op.operand_a ^ op.operand_b;
      NOT:     op.result = ~op.operand_a;  // operand_b ignored
      default: op.result = '0;             // Not a gate opcode
    endcase
  end

  //////////////////////////////////////////////////
  // Elaboration check
  //////////////////////////////////////////////////
  // Index fields are sized for a small register file
  initial begin
    if (`PROC_NUM_REGS > 32) begin
      $warning("%m register count %0d exceeds 32", `PROC_NUM_REGS);
    end
  end

endmodule

`default_nettype wire

//--- src/alu_arith.sv
//////////////////////////////////////////////////
// Arithmetic unit
// Wrapping add and subtract, logical shifts by rs2 low bits
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module alu_arith
  import proc_isa_pkg::*;
(
  alu_op_if.unit op
);

  //////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////
  logic [`PROC_SHAMT_WIDTH-1:0] shamt;     // 0..15
  logic [`PROC_DATA_WIDTH-1:0]  sum;
  logic [`PROC_DATA_WIDTH-1:0]  diff;

  assign shamt = op.operand_b[`PROC_SHAMT_WIDTH-1:0];  // Upper rs2 bits ignored

  // Carry and borrow dropped, modulo 2^16
  assign sum  = op.operand_a + op.operand_b;
  assign diff = op.operand_a - op.operand_b;

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////
  always_comb begin
    case (op.opcode)
      ADD: begin
        op.result = sum;
      end
      SUB: begin
        op.result = diff;
      end
      SLL: begin
        op.result = op.operand_a << shamt;  // Zero fill from the right
      end
      SRL: begin
        op.result = op.operand_a >> shamt;  // Logical, no sign copy
      end
      default: begin
        op.result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/exec_writeback.sv
//////////////////////////////////////////////////
// Writeback stage
// Picks the owning unit's result, writes the register file
// at the sampling edge and registers the top-level outputs
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module exec_writeback
  import proc_isa_pkg::*;
  import proc_exec_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        valid_i,   // Instruction strobe
  input  dec_ctrl_t                   ctrl_i,
  alu_op_if.sink                      gate_res,
  alu_op_if.sink                      arith_res,
  // Register file write port
  output logic                        we_o,
  output reg_idx_t                    wr_idx_o,
  output logic [`PROC_DATA_WIDTH-1:0] wr_data_o,
  // Registered results
  output logic                        result_valid_o,
  output logic [`PROC_DATA_WIDTH-1:0] result_o,
  output reg_idx_t                    rd_o,
  output logic                        zero_o,
  output logic                        illegal_o
);

  logic [`PROC_DATA_WIDTH-1:0] sel_data;

  //////////////////////////////////////////////////
  // Result source
  //////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i.unit_sel)
      UNIT_GATE:  sel_data = gate_res.result;
      UNIT_ARITH: sel_data = arith_res.result;
      UNIT_IMM:   sel_data = ctrl_i.imm;
      default:    sel_data = '0;  // NOP and illegal
    endcase
  end

  // Write at the same edge that samples the instruction
  assign we_o      = valid_i & ctrl_i.we;
  assign wr_idx_o  = ctrl_i.rd;
  assign wr_data_o = sel_data;

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
      rd_o           <= '0;
      zero_o         <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      result_valid_o <= valid_i;                   // One-cycle pulse
      illegal_o      <= valid_i & ctrl_i.illegal;  // Only alongside a valid result
      if (valid_i) begin
        result_o <= sel_data;  // Held between instructions
        rd_o     <= ctrl_i.rd;
        zero_o   <= (sel_data == '0);
      end
    end
  end

endmodule

`default_nettype wire

//--- src/exec_core.sv
//////////////////////////////////////////////////
// Execute slice top level
// One instruction per instr_valid_i strobe, result one cycle later
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module exec_core
  import proc_isa_pkg::*;
  import proc_exec_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         instr_valid_i,
  input  logic [`PROC_INSTR_WIDTH-1:0] instr_i,
  output logic                         result_valid_o,
  output logic [`PROC_DATA_WIDTH-1:0]  result_o,
  output reg_idx_t                     rd_o,
  output logic                         zero_o,
  output logic                         illegal_o
);

  //////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////
  opcode_e                     dec_opcode;
  reg_idx_t                    rs1_idx;
  reg_idx_t                    rs2_idx;
  dec_ctrl_t                   dec_ctrl;
  logic [`PROC_DATA_WIDTH-1:0] rs1_data;
  logic [`PROC_DATA_WIDTH-1:0] rs2_data;
  logic                        wr_en;
  reg_idx_t                    wr_idx;
  logic [`PROC_DATA_WIDTH-1:0] wr_data;

  alu_op_if gate_if ();
  alu_op_if arith_if ();

  // Both units see the same operands and opcode
  assign gate_if.operand_a  = rs1_data;
  assign gate_if.operand_b  = rs2_data;
  assign gate_if.opcode     = dec_opcode;
  assign arith_if.operand_a = rs1_data;
  assign arith_if.operand_b = rs2_data;
  assign arith_if.opcode    = dec_opcode;

  //////////////////////////////////////////////////
  // Decode and operand read
  //////////////////////////////////////////////////
  instr_decoder instr_decoder_i (
    .instr_i  (instr_i),
    .opcode_o (dec_opcode),
    .rs1_o    (rs1_idx),
    .rs2_o    (rs2_idx),
    .ctrl_o   (dec_ctrl)
  );

  reg_file reg_file_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_i      (rs1_idx),
    .rs2_i      (rs2_idx),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data)
  );

  //////////////////////////////////////////////////
  // Function units and writeback
  //////////////////////////////////////////////////
  alu_gate  alu_gate_i  (.op(gate_if.unit));
  alu_arith alu_arith_i (.op(arith_if.unit));

  exec_writeback exec_writeback_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (instr_valid_i),
    .ctrl_i         (dec_ctrl),
    .gate_res       (gate_if.sink),
    .arith_res      (arith_if.sink),
    .we_o           (wr_en),
    .wr_idx_o       (wr_idx),
    .wr_data_o      (wr_data),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .rd_o           (rd_o),
    .zero_o         (zero_o),
    .illegal_o      (illegal_o)
  );

endmodule

`default_nettype wire

//--- test/exec_core_properties.sv
//////////////////////////////////////////////////
// Concurrent assertions on the execute slice outputs
// Bound to exec_core, one cycle result timing and flags
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module exec_core_properties (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           valid_i,         // instr_valid_i
  input logic                           result_valid_i,
  input logic [`PROC_DATA_WIDTH-1:0]    result_i,
  input logic [`PROC_REG_IDX_WIDTH-1:0] rd_i,
  input logic                           zero_i,
  input logic                           illegal_i
);

  // Result strobe one cycle after the instruction strobe
  a_valid_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> (result_valid_i == $past(valid_i)))
    else $error("result_valid_o does not follow instr_valid_i by one cycle");

  a_illegal_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    illegal_i |-> result_valid_i)
    else $error("illegal_o high without result_valid_o");

  a_zero_flag: assert property (@(posedge clk_i) disable iff (rst_i)
    result_valid_i |-> (zero_i == (result_i == '0)))
    else $error("zero_o disagrees with result_o");

  a_no_x: assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown({result_valid_i, result_i, rd_i, zero_i, illegal_i}))
    else $error("Unknown value on an exec_core output");

endmodule

bind exec_core exec_core_properties exec_core_properties_i (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .valid_i        (instr_valid_i),
  .result_valid_i (result_valid_o),
  .result_i       (result_o),
  .rd_i           (rd_o),
  .zero_i         (zero_o),
  .illegal_i      (illegal_o)
);

`default_nettype wire

//--- test/exec_core_tb.sv
//////////////////////////////////////////////////
// Testbench for the execute slice
// Directed table, then an xorshift random stream,
// both checked against a register model
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "proc_defs.svh"

module exec_core_tb
  import proc_isa_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int TABLE_ROWS   = 29;
  localparam int RAND_COUNT   = 200;
  localparam int WATCHDOG_NS  = (TABLE_ROWS + RAND_COUNT + 50) * CLK_PERIOD * 2;

  logic                          clk_i;
  logic                          rst_i;
  logic                          instr_valid_i;
  logic [`PROC_INSTR_WIDTH-1:0]  instr_i;
  logic                          result_valid_o;
  logic [`PROC_DATA_WIDTH-1:0]   result_o;
  logic [`PROC_REG_IDX_WIDTH-1:0] rd_o;
  logic                          zero_o;
  logic                          illegal_o;

  // Stimulus table with one row per cycle
  logic        tbl_valid  [TABLE_ROWS];
  logic [15:0] tbl_instr  [TABLE_ROWS];
  logic [15:0] tbl_result [TABLE_ROWS];
  logic [2:0]  tbl_rd     [TABLE_ROWS];
  logic        tbl_zero   [TABLE_ROWS];
  logic        tbl_ill    [TABLE_ROWS];
  int          row_count;

  logic [15:0] model_regs [`PROC_NUM_REGS];  // Register model
  logic        exp_valid;                    // Instruction in flight
  logic [15:0] exp_result;                   // Last valid instruction's values
  logic [2:0]  exp_rd;
  logic        exp_zero;
  logic        exp_ill;
  int          error_count;
  int          check_count;
  logic [31:0] rng_state;

  exec_core exec_core_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .rd_o           (rd_o),
    .zero_o         (zero_o),
    .illegal_o      (illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Ends a hung run
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

  //////////////////////////////////////////////////
  // Encoding and reference rules
  //////////////////////////////////////////////////
  function automatic logic [15:0] enc_reg(input logic [3:0] opc, input logic [2:0] rd,
                                          input logic [2:0] rs1, input logic [2:0] rs2);
    return {opc, rd, rs1, rs2, 3'b000};  // Low bits unused
  endfunction

  function automatic logic [15:0] enc_ldi(input logic [2:0] rd, input logic [8:0] imm);
    return {4'h9, rd, imm};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] predict_result(input logic [15:0] instr);
    logic [15:0] a;
    logic [15:0] b;
    a = model_regs[instr[8:6]];
    b = model_regs[instr[5:3]];
    case (opcode_e'(instr[15:12]))
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      NOT:     return ~a;          // rs2 plays no part
      ADD:     return a + b;       // Wraps at 16 bits
      SUB:     return a - b;
      SLL:     return a << b[3:0];
      SRL:     return a >> b[3:0];
      LDI:     return {7'd0, instr[8:0]};
      default: return 16'h0000;    // NOP and codes 10..15
    endcase
  endfunction

  function automatic logic writes_register(input logic [15:0] instr);
    return (instr[15:12] >= 4'd1) && (instr[15:12] <= 4'd9);
  endfunction

  //////////////////////////////////////////////////
  // Checking and driving
  //////////////////////////////////////////////////
  task automatic add_row(input logic valid, input logic [15:0] instr, input logic [15:0] res,
                         input logic [2:0] rd, input logic zero, input logic ill);
    tbl_valid[row_count]  = valid;
    tbl_instr[row_count]  = instr;
    tbl_result[row_count] = res;
    tbl_rd[row_count]     = rd;
    tbl_zero[row_count]   = zero;
    tbl_ill[row_count]    = ill;
    row_count++;
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("Fail %s: got 0x%h expected 0x%h at %0t", name, got, expected, $time);
    end
  endtask

  // Outputs of the instruction driven one cycle earlier, held while idle
  task automatic check_previous();
    check_value("result_valid_o", {15'd0, result_valid_o}, {15'd0, exp_valid});
    check_value("result_o", result_o, exp_result);
    check_value("rd_o", {13'd0, rd_o}, {13'd0, exp_rd});
    check_value("zero_o", {15'd0, zero_o}, {15'd0, exp_zero});
    // Only raised alongside result_valid_o
    check_value("illegal_o", {15'd0, illegal_o}, {15'd0, exp_valid & exp_ill});
  endtask

  task automatic drive_step(input logic valid, input logic [15:0] instr, input logic [15:0] res,
                            input logic [2:0] rd, input logic zero, input logic ill);
    @(negedge clk_i);
    check_previous();
    instr_valid_i = valid;
    instr_i       = instr;
    exp_valid     = valid;
    if (valid) begin
      exp_result = res;
      exp_rd     = rd;
      exp_zero   = zero;
      exp_ill    = ill;
    end
    if (valid && writes_register(instr)) begin
      model_regs[instr[11:9]] = predict_result(instr);  // Lands at the sampling edge
    end
  endtask

  task automatic build_table();
    add_row(1'b0, 16'h0000, 16'h0000, 3'd0, 1'b0, 1'b0);  // Idle after reset
    // Every register reads zero
    add_row(1'b1, enc_reg(OR,  3'd0, 3'd0, 3'd1), 16'h0000, 3'd0, 1'b1, 1'b0);
    add_row(1'b1, enc_reg(ADD, 3'd0, 3'd2, 3'd3), 16'h0000, 3'd0, 1'b1, 1'b0);
    add_row(1'b1, enc_reg(XOR, 3'd0, 3'd4, 3'd5), 16'h0000, 3'd0, 1'b1, 1'b0);
    add_row(1'b1, enc_reg(OR,  3'd0, 3'd6, 3'd7), 16'h0000, 3'd0, 1'b1, 1'b0);
    // Logic ops
    add_row(1'b1, enc_ldi(3'd1, 9'h0F3), 16'h00F3, 3'd1, 1'b0, 1'b0);
    add_row(1'b1, enc_ldi(3'd2, 9'h1A5), 16'h01A5, 3'd2, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(AND, 3'd3, 3'd1, 3'd2), 16'h00A1, 3'd3, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(OR,  3'd4, 3'd1, 3'd2), 16'h01F7, 3'd4, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(XOR, 3'd5, 3'd1, 3'd2), 16'h0156, 3'd5, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(NOT, 3'd6, 3'd1, 3'd2), 16'hFF0C, 3'd6, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(NOT, 3'd7, 3'd1, 3'd0), 16'hFF0C, 3'd7, 1'b0, 1'b0);
    add_row(1'b0, 16'h0000, 16'h0000, 3'd0, 1'b0, 1'b0);
    // Arithmetic with several rows reading the register written just before
    add_row(1'b1, enc_ldi(3'd1, 9'h001), 16'h0001, 3'd1, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(SUB, 3'd2, 3'd0, 3'd1), 16'hFFFF, 3'd2, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(ADD, 3'd3, 3'd2, 3'd1), 16'h0000, 3'd3, 1'b1, 1'b0);
    add_row(1'b1, enc_reg(SUB, 3'd4, 3'd1, 3'd1), 16'h0000, 3'd4, 1'b1, 1'b0);
    add_row(1'b1, enc_ldi(3'd5, 9'h014), 16'h0014, 3'd5, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(SLL, 3'd6, 3'd2, 3'd5), 16'hFFF0, 3'd6, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(SRL, 3'd7, 3'd6, 3'd5), 16'h0FFF, 3'd7, 1'b0, 1'b0);
    add_row(1'b1, enc_ldi(3'd5, 9'h1F3), 16'h01F3, 3'd5, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(SLL, 3'd6, 3'd1, 3'd5), 16'h0008, 3'd6, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(ADD, 3'd6, 3'd6, 3'd6), 16'h0010, 3'd6, 1'b0, 1'b0);
    // Illegal codes and NOP followed by a read back of r7, r6 and r2
    add_row(1'b1, enc_reg(4'hA, 3'd7, 3'd1, 3'd1), 16'h0000, 3'd7, 1'b1, 1'b1);
    add_row(1'b1, enc_reg(4'hF, 3'd6, 3'd2, 3'd5), 16'h0000, 3'd6, 1'b1, 1'b1);
    add_row(1'b1, enc_reg(NOP, 3'd2, 3'd1, 3'd1), 16'h0000, 3'd2, 1'b1, 1'b0);
    add_row(1'b1, enc_reg(OR,  3'd1, 3'd7, 3'd0), 16'h0FFF, 3'd1, 1'b0, 1'b0);
    add_row(1'b1, enc_reg(XOR, 3'd3, 3'd6, 3'd2), 16'hFFEF, 3'd3, 1'b0, 1'b0);
    add_row(1'b0, 16'h0000, 16'h0000, 3'd0, 1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    logic [3:0]  opc;
    logic [15:0] instr;
    logic [15:0] res;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    exp_valid     = 1'b0;
    exp_result    = '0;  // Reset values of the outputs
    exp_rd        = '0;
    exp_zero      = 1'b0;
    exp_ill       = 1'b0;
    error_count   = 0;
    check_count   = 0;
    row_count     = 0;
    rng_state     = 32'd64323;
    for (int i = 0; i < `PROC_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    build_table();
    if (row_count != TABLE_ROWS) begin
      error_count++;
      $display("Stimulus table holds %0d rows instead of %0d", row_count, TABLE_ROWS);
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check_previous();  // Reset values with nothing in flight

    for (int i = 0; i < TABLE_ROWS; i++) begin
      drive_step(tbl_valid[i], tbl_instr[i], tbl_result[i], tbl_rd[i], tbl_zero[i],
                 tbl_ill[i]);
    end

    // Random mix with illegal codes thinned out
    for (int i = 0; i < RAND_COUNT; i++) begin
      rng_state = xorshift32(rng_state);
      opc = rng_state[3:0];
      if (opc > 4'd9 && rng_state[4]) begin
        opc = opc - 4'd6;
      end
      instr = {opc, rng_state[16:5]};
      res   = predict_result(instr);
      drive_step(1'b1, instr, res, instr[11:9], res == 16'h0000, opc > 4'd9);
    end
    drive_step(1'b0, 16'h0000, 16'h0000, 3'd0, 1'b0, 1'b0);  // Drain
    drive_step(1'b0, 16'h0000, 16'h0000, 3'd0, 1'b0, 1'b0);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_core.f
+incdir+src
src/proc_isa_pkg.sv
src/proc_exec_pkg.sv
src/alu_op_if.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu_gate.sv
src/alu_arith.sv
src/exec_writeback.sv
src/exec_core.sv
test/exec_core_properties.sv
test/exec_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the execute slice testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f exec_core.f --top-module exec_core_tb -Mdir obj_dir -o Vexec_core_tb; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vexec_core_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
